// File: filelist.f
+incdir+logic
+incdir+testbench
logic/apb_pkg.sv
logic/apb_delayer.sv
logic/apb_decoder.sv
logic/apb_sram.sv
logic/apb_counter_regs.sv
logic/apb_delay_top.sv
testbench/tb_apb_delay.sv

// File: logic/apb_counter_regs.sv
`timescale 1ns/1ps
`include "delay_consts.svh"

module apb_counter_regs (
    input  logic              clock,
    input  logic              reset,
    input  apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t rsp
);

    localparam logic [31:0] OFF_CYCLES  = 32'h0;
    localparam logic [31:0] OFF_SCRATCH = 32'h4;
    localparam logic [31:0] OFF_ID      = 32'h8;
    localparam logic [`APB_DATA_W-1:0] ID_WORD = 32'h4450_4C59;

    logic [`APB_DATA_W-1:0] cycle_count;
    logic [`APB_DATA_W-1:0] scratch;
    logic [`APB_DATA_W-1:0] rd_data;
    logic [31:0]            offset;
    logic                   access;
    logic                   illegal;

    assign offset = req.paddr & ~`REGION_MASK;
    assign access = req.psel && req.penable;

    always_ff @(posedge clock) begin
        if (reset) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1; // Free running
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            scratch <= '0;
        end else if (access && req.pwrite && (offset == OFF_SCRATCH)) begin
            for (int b = 0; b < `APB_STRB_W; b++) begin
                if (req.pstrb[b]) begin
                    scratch[8*b +: 8] <= req.pwdata[8*b +: 8];
                end
            end
        end
    end

    // #################### Read decode
    always_comb begin
        case (offset)
            OFF_CYCLES: begin
                rd_data = cycle_count;
                illegal = req.pwrite; // Read only
            end
            OFF_SCRATCH: begin
                rd_data = scratch;
                illegal = 1'b0;
            end
            OFF_ID: begin
                rd_data = ID_WORD;
                illegal = req.pwrite;
            end
            default: begin
                rd_data = '0;
                illegal = 1'b1;
            end
        endcase
    end

    assign rsp.pready  = access;
    assign rsp.pslverr = access && illegal;
    assign rsp.prdata  = (access && !req.pwrite && !illegal) ? rd_data : '0;

endmodule

// File: logic/apb_decoder.sv
`timescale 1ns/1ps
`include "delay_consts.svh"

module apb_decoder (
    input  logic              clock,
    input  logic              reset,
    input  apb_pkg::apb_req_t mid_req,
    output apb_pkg::apb_rsp_t mid_rsp,
    output apb_pkg::apb_req_t sram_req,
    output apb_pkg::apb_req_t regs_req,
    input  apb_pkg::apb_rsp_t sram_rsp,
    input  apb_pkg::apb_rsp_t regs_rsp
);

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_SRAM,
        REGION_REGS
    } region_t;

    region_t region_now;
    region_t region_q;
    region_t region;
    logic    access;

    always_comb begin
        region_now = REGION_NONE;
        if ((mid_req.paddr & `REGION_MASK) == `SRAM_BASE) begin
            region_now = REGION_SRAM;
        end else if ((mid_req.paddr & `REGION_MASK) == `REGS_BASE) begin
            region_now = REGION_REGS;
        end
    end

    // Region is fixed at setup and held through the access phase
    always_ff @(posedge clock) begin
        if (reset) begin
            region_q <= REGION_NONE;
        end else if (mid_req.psel && !mid_req.penable) begin
            region_q <= region_now;
        end
    end

    assign region = mid_req.penable ? region_q : region_now;
    assign access = mid_req.psel && mid_req.penable;

    // #################### Request routing
    always_comb begin
        sram_req         = mid_req;
        regs_req         = mid_req;
        sram_req.psel    = mid_req.psel && (region == REGION_SRAM);
        sram_req.penable = mid_req.penable && (region == REGION_SRAM);
        regs_req.psel    = mid_req.psel && (region == REGION_REGS);
        regs_req.penable = mid_req.penable && (region == REGION_REGS);
    end

    // #################### Response mux
    always_comb begin
        case (region)
            REGION_SRAM: begin
                mid_rsp = sram_rsp;
            end
            REGION_REGS: begin
                mid_rsp = regs_rsp;
            end
            default: begin
                mid_rsp.pready  = access; // Unmapped completes at once
                mid_rsp.prdata  = '0;
                mid_rsp.pslverr = access;
            end
        endcase
    end

endmodule

// File: logic/apb_delay_top.sv
`timescale 1ns/1ps

module apb_delay_top (
    input  logic              clock,
    input  logic              reset,
    input  apb_pkg::apb_req_t up_req,
    output apb_pkg::apb_rsp_t up_rsp
);

    apb_pkg::apb_req_t mid_req;
    apb_pkg::apb_rsp_t mid_rsp;
    apb_pkg::apb_req_t sram_req;
    apb_pkg::apb_rsp_t sram_rsp;
    apb_pkg::apb_req_t regs_req;
    apb_pkg::apb_rsp_t regs_rsp;

    apb_delayer u_delayer (
        .clock    (clock),
        .reset    (reset),
        .up_req   (up_req),
        .up_rsp   (up_rsp),
        .down_req (mid_req),
        .down_rsp (mid_rsp)
    );

    apb_decoder u_decoder (
        .clock    (clock),
        .reset    (reset),
        .mid_req  (mid_req),
        .mid_rsp  (mid_rsp),
        .sram_req (sram_req),
        .regs_req (regs_req),
        .sram_rsp (sram_rsp),
        .regs_rsp (regs_rsp)
    );

    apb_sram u_sram (
        .clock (clock),
        .reset (reset),
        .req   (sram_req),
        .rsp   (sram_rsp)
    );

    apb_counter_regs u_regs (
        .clock (clock),
        .reset (reset),
        .req   (regs_req),
        .rsp   (regs_rsp)
    );

endmodule

// File: logic/apb_delayer.sv
`timescale 1ns/1ps
`include "delay_consts.svh"

module apb_delayer (
    input  logic              clock,
    input  logic              reset,
    input  apb_pkg::apb_req_t up_req,
    output apb_pkg::apb_rsp_t up_rsp,
    output apb_pkg::apb_req_t down_req,
    input  apb_pkg::apb_rsp_t down_rsp
);

    if (`DELAY_ENABLE != 0) begin : g_delay
        typedef enum logic [1:0] {
            IDLE,
            ACTIVE,
            DRAINING,
            RESPONDING
        } state_t;

        localparam logic [31:0] RATIO = 32'(`DELAY_RATIO);

        state_t                 state;
        logic [31:0]            acc; // Wait cycles times the ratio in fixed point
        logic [31:0]            wait_count;
        logic [31:0]            drain_count;
        logic [31:0]            scaled;
        logic [31:0]            remain;
        logic [`APB_DATA_W-1:0] cap_prdata;
        logic                   cap_pslverr;
        apb_pkg::apb_rsp_t      rsp_q;
        logic                   pass;
        logic                   access;
        logic                   done;

        assign pass   = (state == IDLE) || (state == ACTIVE);
        assign access = (state == ACTIVE) && up_req.psel && up_req.penable;
        assign done   = access && down_rsp.pready;
        assign scaled = acc >> `DELAY_FRAC_BITS;
        assign remain = (scaled > wait_count) ? scaled - wait_count : '0;

        // The slave sees each transfer once, so the request is held off after it completes
        always_comb begin
            down_req = up_req;
            if (!pass) begin
                down_req.psel    = 1'b0;
                down_req.penable = 1'b0;
            end
        end

        // #################### FSM
        always_ff @(posedge clock) begin
            if (reset) begin
                state <= IDLE;
            end else begin
                case (state)
                    IDLE: begin
                        if (up_req.psel && !up_req.penable) begin
                            state <= ACTIVE;
                        end
                    end
                    ACTIVE: begin
                        if (done) begin
                            state <= (remain == '0) ? RESPONDING : DRAINING;
                        end
                    end
                    DRAINING: begin
                        if (drain_count == 32'd1) begin
                            state <= RESPONDING;
                        end
                    end
                    default: begin
                        state <= IDLE; // One cycle of upstream completion
                    end
                endcase
            end
        end

        // #################### Counters
        always_ff @(posedge clock) begin
            if (reset) begin
                acc         <= '0;
                wait_count  <= '0;
                drain_count <= '0;
            end else if (done) begin
                acc         <= '0;
                wait_count  <= '0;
                drain_count <= remain; // Extra cycles still owed upstream
            end else if (access) begin
                acc        <= acc + RATIO;
                wait_count <= wait_count + 32'd1;
            end else if (state == DRAINING) begin
                drain_count <= drain_count - 32'd1;
            end
        end

        always_ff @(posedge clock) begin
            if (done) begin
                cap_prdata  <= down_rsp.prdata;
                cap_pslverr <= down_rsp.pslverr;
            end
        end

        // #################### Upstream response
        always_ff @(posedge clock) begin
            if (reset) begin
                rsp_q <= '0;
            end else if (done && (remain == '0)) begin
                rsp_q <= '{pready: 1'b1, prdata: down_rsp.prdata, pslverr: down_rsp.pslverr};
            end else if ((state == DRAINING) && (drain_count == 32'd1)) begin
                rsp_q <= '{pready: 1'b1, prdata: cap_prdata, pslverr: cap_pslverr};
            end else begin
                rsp_q <= '0; // Data stays zero outside the completing cycle
            end
        end

        assign up_rsp = rsp_q;
    end else begin : g_wire
        assign down_req = up_req;
        assign up_rsp   = down_rsp;
    end

endmodule

// File: logic/apb_pkg.sv
`include "delay_consts.svh"

package apb_pkg;

    // Request from requester to completer in 74 bits
    typedef struct packed {
        logic [`APB_ADDR_W-1:0] paddr;
        logic                   psel;
        logic                   penable;
        logic [2:0]             pprot;
        logic                   pwrite;
        logic [`APB_DATA_W-1:0] pwdata;
        logic [`APB_STRB_W-1:0] pstrb;
    } apb_req_t;

    // Response from completer to requester in 34 bits
    typedef struct packed {
        logic                   pready;
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pslverr;
    } apb_rsp_t;

endpackage

// File: logic/apb_sram.sv
`timescale 1ns/1ps
`include "delay_consts.svh"

module apb_sram (
    input  logic              clock,
    input  logic              reset,
    input  apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t rsp
);

    localparam int IDX_W = $clog2(`SRAM_WORDS);
    localparam int CNT_W = $clog2(`SRAM_WAIT_CYCLES + 2);
    localparam logic [CNT_W-1:0] WAIT = CNT_W'(`SRAM_WAIT_CYCLES);

    logic [`APB_DATA_W-1:0] mem [`SRAM_WORDS];
    logic [31:0]            word_addr;
    logic [IDX_W-1:0]       index;
    logic                   in_range;
    logic                   access;
    logic                   ready;
    logic [CNT_W-1:0]       wait_count;

    assign word_addr = (req.paddr & ~`REGION_MASK) >> 2;
    assign in_range  = word_addr < `SRAM_WORDS;
    assign index     = word_addr[IDX_W-1:0];
    assign access    = req.psel && req.penable;
    assign ready     = access && (wait_count == WAIT);

    // #################### Wait states
    always_ff @(posedge clock) begin
        if (reset) begin
            wait_count <= '0;
        end else if (access && !ready) begin
            wait_count <= wait_count + 1'b1;
        end else begin
            wait_count <= '0;
        end
    end

    // #################### Storage
    always_ff @(posedge clock) begin
        if (ready && req.pwrite && in_range) begin
            for (int b = 0; b < `APB_STRB_W; b++) begin
                if (req.pstrb[b]) begin
                    mem[index][8*b +: 8] <= req.pwdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        rsp.pready  = ready;
        rsp.pslverr = ready && !in_range; // Beyond the depth
        if (ready && !req.pwrite && in_range) begin
            rsp.prdata = mem[index];
        end else begin
            rsp.prdata = '0;
        end
    end

endmodule

// File: logic/delay_consts.svh
`ifndef DELAY_CONSTS_SVH
`define DELAY_CONSTS_SVH

// #################### Bus widths
`define APB_ADDR_W 32
`define APB_DATA_W 32
`define APB_STRB_W 4

// #################### Latency scaling
`define DELAY_FRAC_BITS 10
`define DELAY_RATIO 2048 // 2.0 in Q.10
`define DELAY_ENABLE 1 // Set to 0 to turn the delayer into wires

// #################### Slaves
`define SRAM_WAIT_CYCLES 3
`define SRAM_WORDS 256

// #################### Address map
`define SRAM_BASE 32'h8000_0000
`define REGS_BASE 32'h1000_0000
`define REGION_MASK 32'hFFFF_F000

`endif

// File: testbench/tb_apb_tasks.svh
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// Upstream wait count is floor(w * ratio) + 1 where w is the slave's own wait count
localparam int SRAM_WAITS = ((`SRAM_WAIT_CYCLES * `DELAY_RATIO) >> `DELAY_FRAC_BITS) + 1;
localparam int FAST_WAITS = ((0 * `DELAY_RATIO) >> `DELAY_FRAC_BITS) + 1;

int          check_errors = 0;
logic [31:0] model_mem [`SRAM_WORDS]; // Expected SRAM contents

// #################### Bus access
task automatic apb_transfer(input logic [31:0] addr, input logic write,
                            input logic [31:0] wdata, input logic [3:0] strb,
                            output logic [31:0] rdata, output logic err, output int waits);
    waits = 0;
    @(posedge clock);
    up_req <= '{paddr: addr, psel: 1'b1, penable: 1'b0, pprot: 3'b000, pwrite: write,
                pwdata: wdata, pstrb: strb};
    @(posedge clock);
    up_req.penable <= 1'b1;
    @(negedge clock);
    while (!up_rsp.pready) begin
        waits++; // Access cycle with pready low
        @(negedge clock);
    end
    rdata = up_rsp.prdata;
    err   = up_rsp.pslverr;
endtask

task automatic check_value(input string test_name, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
        $display("** Error: %s: %s expected %h, actual %h", test_name, what, expected, actual);
        check_errors++;
    end
endtask

task automatic access_checked(input string test_name, input logic [31:0] addr,
                              input logic write, input logic [31:0] wdata,
                              input logic [3:0] strb, input int exp_waits,
                              input logic exp_err, output logic [31:0] rdata);
    logic err;
    int   waits;
    apb_transfer(addr, write, wdata, strb, rdata, err, waits);
    check_value(test_name, "wait count", exp_waits, waits);
    check_value(test_name, "pslverr", exp_err, err);
endtask

// Drops psel for one cycle and checks that the upstream response stays quiet
task automatic bus_idle(input string test_name);
    @(posedge clock);
    up_req <= '0;
    @(negedge clock);
    check_value(test_name, "idle pready", 32'd0, up_rsp.pready);
    check_value(test_name, "idle prdata", 32'd0, up_rsp.prdata);
endtask

// #################### Memory model
function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                            input logic [3:0] strb);
    logic [31:0] result;
    result = old;
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
            result[8*b +: 8] = data[8*b +: 8];
        end
    end
    return result;
endfunction

function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9E37_79B9) ^ 32'h5A5A_A5A5;
endfunction

task automatic sram_write(input string test_name, input int index, input logic [31:0] data,
                          input logic [3:0] strb);
    logic [31:0] unused;
    access_checked(test_name, `SRAM_BASE + 32'(index * 4), 1'b1, data, strb, SRAM_WAITS,
                   1'b0, unused);
    model_mem[index] = merge_bytes(model_mem[index], data, strb);
endtask

task automatic sram_read_check(input string test_name, input int index);
    logic [31:0] rdata;
    access_checked(test_name, `SRAM_BASE + 32'(index * 4), 1'b0, '0, '0, SRAM_WAITS,
                   1'b0, rdata);
    check_value(test_name, "read data", model_mem[index], rdata);
endtask

`endif

// File: testbench/tb_apb_delay.sv
`timescale 1ns/1ps
`include "delay_consts.svh"

module tb_apb_delay;

    localparam logic [31:0] UNMAPPED    = 32'h4000_0010;
    localparam logic [31:0] REG_CYCLES  = `REGS_BASE + 32'h0;
    localparam logic [31:0] REG_SCRATCH = `REGS_BASE + 32'h4;
    localparam logic [31:0] REG_ID      = `REGS_BASE + 32'h8;
    localparam logic [31:0] REG_UNDEF   = `REGS_BASE + 32'hC;
    localparam logic [31:0] SRAM_BEYOND = `SRAM_BASE + 4 * `SRAM_WORDS;
    localparam int FILL_WORDS     = 16; // Window shared with the random traffic
    localparam int RANDOM_COUNT   = 40;
    localparam int TRANSFER_COUNT = 2 * FILL_WORDS + 3 + 8 + 5 + RANDOM_COUNT;
    localparam int CYCLE_LIMIT    = TRANSFER_COUNT * (2 * `SRAM_WAIT_CYCLES + 10) + 50;

    logic              clock = 1'b0;
    logic              reset;
    apb_pkg::apb_req_t up_req;
    apb_pkg::apb_rsp_t up_rsp;
    int                tests_run = 0;
    int                tests_failed = 0;

    `include "tb_apb_tasks.svh"

    always #50 clock = ~clock;

    apb_delay_top dut (.clock(clock), .reset(reset), .up_req(up_req), .up_rsp(up_rsp));

    task automatic report_test(input string test_name, input int errors_before);
        tests_run++;
        if (check_errors == errors_before) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d checks failed", test_name, check_errors - errors_before);
        end
    endtask

    // #################### Tests
    task automatic reset_quiet();
        int errors_before;
        errors_before = check_errors;
        repeat (3) begin
            @(negedge clock);
            check_value("reset_state", "pready", 32'd0, up_rsp.pready);
            check_value("reset_state", "prdata", 32'd0, up_rsp.prdata);
        end
        report_test("reset_state", errors_before);
    endtask

    task automatic memory_access();
        int errors_before;
        errors_before = check_errors;
        for (int i = 0; i < FILL_WORDS; i++) begin
            sram_write("memory", i, fill_word(`SRAM_BASE + 32'(4 * i)), 4'hF);
        end
        sram_write("memory", 1, 32'hA1B2_C3D4, 4'b0001);
        sram_write("memory", 2, 32'h1122_3344, 4'b0110);
        sram_write("memory", 3, 32'hDEAD_BEEF, 4'b1000);
        for (int i = 0; i < FILL_WORDS; i++) begin
            sram_read_check("memory", i);
        end
        bus_idle("memory");
        report_test("memory", errors_before);
    endtask

    task automatic register_slave();
        int          errors_before;
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] rdata;
        errors_before = check_errors;
        access_checked("registers", REG_SCRATCH, 1'b1, 32'hFFFF_FFFF, 4'hF, FAST_WAITS, 1'b0,
                       rdata);
        access_checked("registers", REG_SCRATCH, 1'b1, 32'h1234_5678, 4'b0101, FAST_WAITS, 1'b0,
                       rdata);
        access_checked("registers", REG_SCRATCH, 1'b0, '0, '0, FAST_WAITS, 1'b0, rdata);
        check_value("registers", "scratch", 32'hFF34_FF78, rdata);
        access_checked("registers", REG_ID, 1'b0, '0, '0, FAST_WAITS, 1'b0, rdata);
        check_value("registers", "identity", 32'h4450_4C59, rdata);
        access_checked("registers", REG_CYCLES, 1'b0, '0, '0, FAST_WAITS, 1'b0, first);
        access_checked("registers", REG_CYCLES, 1'b0, '0, '0, FAST_WAITS, 1'b0, second);
        assert (second > first) else begin
            $display("** Error: registers: counter expected above %h, actual %h", first, second);
            check_errors++;
        end
        access_checked("registers", REG_CYCLES, 1'b1, 32'h0, 4'hF, FAST_WAITS, 1'b1, rdata);
        access_checked("registers", REG_UNDEF, 1'b0, '0, '0, FAST_WAITS, 1'b1, rdata);
        bus_idle("registers");
        report_test("registers", errors_before);
    endtask

    task automatic decode_errors();
        int          errors_before;
        logic [31:0] rdata;
        errors_before = check_errors;
        access_checked("errors", UNMAPPED, 1'b0, '0, '0, FAST_WAITS, 1'b1, rdata);
        check_value("errors", "unmapped prdata", 32'd0, rdata);
        access_checked("errors", UNMAPPED, 1'b1, 32'hFFFF_FFFF, 4'hF, FAST_WAITS, 1'b1, rdata);
        access_checked("errors", SRAM_BEYOND, 1'b1, 32'h0BAD_0BAD, 4'hF, SRAM_WAITS, 1'b1, rdata);
        access_checked("errors", SRAM_BEYOND, 1'b0, '0, '0, SRAM_WAITS, 1'b1, rdata);
        check_value("errors", "range prdata", 32'd0, rdata);
        sram_read_check("errors", 0); // The range write wraps onto this index if it leaks
        bus_idle("errors");
        report_test("errors", errors_before);
    endtask

    task automatic random_traffic();
        int          errors_before;
        int          index;
        logic [31:0] data;
        logic [3:0]  strb;
        errors_before = check_errors;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            index = $urandom_range(FILL_WORDS - 1);
            data  = $urandom();
            strb  = 4'($urandom());
            if ($urandom_range(1) == 1) begin
                sram_write("random", index, data, strb);
            end else begin
                sram_read_check("random", index);
            end
        end
        bus_idle("random");
        report_test("random", errors_before);
    endtask

    // #################### Run control
    initial begin : watchdog
        repeat (CYCLE_LIMIT) @(posedge clock);
        $display("Watchdog expired after %0d cycles, a transfer never completed", CYCLE_LIMIT);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        reset  = 1'b1;
        up_req = '0;
        void'($urandom(32'h18575e4c));
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        reset_quiet();
        memory_access();
        register_slave();
        decode_errors();
        random_traffic();
        $display("Tests run: %0d, tests failed: %0d, checks failed: %0d", tests_run,
                 tests_failed, check_errors);
        if (tests_failed == 0 && check_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
